// ==== design/addr_dec_resp_mux_varlat.sv ====
/* Bank decoder and response mux */

module addr_dec_resp_mux_varlat #(
  parameter int unsigned NumOut        = 4,
  parameter int unsigned ReqDataWidth  = 21,
  parameter int unsigned RespDataWidth = 16
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // master side
  input  logic                                 req_i,
  input  logic [(NumOut > 1 ? $clog2(NumOut) : 1)-1:0] add_i,
  input  logic [ReqDataWidth-1:0]              data_i,
  output logic                                 gnt_o,
  output logic                                 vld_o,
  output logic [RespDataWidth-1:0]             rdata_o,
  // bank side
  output logic [NumOut-1:0]                    req_o,
  output logic [NumOut-1:0][ReqDataWidth-1:0]  data_o,
  input  logic [NumOut-1:0]                    gnt_i,
  input  logic [NumOut-1:0]                    vld_i,
  input  logic [NumOut-1:0][RespDataWidth-1:0] rdata_i
);

  localparam int unsigned SelWidth = NumOut > 1 ? $clog2(NumOut) : 1;

  // one transaction outstanding
  logic inflight_d, inflight_q;

  // same payload to every bank
  assign data_o = {NumOut{data_i}};

  // any bank grant is the master grant
  assign gnt_o = |gnt_i;

  ////////////////////////////////////////////////////////////////////////////
  // single bank
  ////////////////////////////////////////////////////////////////////////////
  if (NumOut == 1) begin : gen_one_output

    // nothing to select
    assign rdata_o = rdata_i[0];
    assign vld_o   = vld_i[0] & inflight_q;

    always_comb begin : p_req_gate
      inflight_d = inflight_q;
      req_o      = '0;
      // pass through when idle or in the response cycle
      if (!inflight_q || vld_o) begin
        req_o[0]   = req_i;
        inflight_d = req_i & gnt_o;
      end
    end

  ////////////////////////////////////////////////////////////////////////////
  // several banks
  ////////////////////////////////////////////////////////////////////////////
  end else begin : gen_several_outputs

    // bank of the outstanding transaction
    logic [SelWidth-1:0] bank_sel_q;

    assign rdata_o = rdata_i[bank_sel_q];
    assign vld_o   = vld_i[bank_sel_q] & inflight_q;

    always_comb begin : p_addr_dec
      inflight_d = inflight_q;
      req_o      = '0;
      // gated while waiting, reopened when the response shows up
      if (!inflight_q || vld_o) begin
        req_o[add_i] = req_i;
        inflight_d   = req_i & gnt_o;
      end
    end

    // remember where the response comes from
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_bank_sel
      if (!rst_ni) begin
        bank_sel_q <= '0;
      end else if (req_i && gnt_o) begin
        bank_sel_q <= add_i;
      end
    end

  end

  // in-flight flag, set on acceptance, cleared by the response
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_inflight
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// ==== design/bank_ctrl_fsm.sv ====
/* Bank control FSM */

module bank_ctrl_fsm #(
  parameter int unsigned BaseLatency = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  // request from the decoder
  input  logic req_i,
  // end of the access latency
  input  logic timer_done_i,
  output logic gnt_o,
  // storage strobe, same cycle as the grant
  output logic access_o,
  output logic timer_start_o,
  // response strobe
  output logic vld_o
);

  ////////////////////////////////////////////////////////////////////////////
  // elaboration checks
  ////////////////////////////////////////////////////////////////////////////

  // RESP needs at least one WAIT cycle before it
  if (BaseLatency < 1) begin : gen_bad_base
    $error("bank base latency must be at least one cycle");
  end

  // extra latency comes out of the word address
  if (varlat_mem_pkg::LatExtraWidth > varlat_mem_pkg::WordAddrWidth) begin : gen_bad_extra
    $error("latency extra bits exceed the word address width");
  end

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    Idle = 2'd0,
    Wait = 2'd1,
    Resp = 2'd2
  } state_e;

  state_e state_d, state_q;

  // accept only when free
  assign gnt_o         = req_i && (state_q == Idle);
  assign access_o      = gnt_o;
  assign timer_start_o = gnt_o;
  // one cycle strobe
  assign vld_o         = (state_q == Resp);

  always_comb begin : p_next_state
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (gnt_o) begin
          state_d = Wait;
        end
      end
      Wait: begin
        // timer counts the remaining latency
        if (timer_done_i) begin
          state_d = Resp;
        end
      end
      Resp: begin
        // back to idle, a new grant comes next cycle
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== design/bank_latency_timer.sv ====
/* Bank latency timer */

module bank_latency_timer #(
  parameter int unsigned BaseLatency = 1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     start_i,
  // low word address bits
  input  logic [varlat_mem_pkg::LatExtraWidth-1:0] extra_i,
  output logic                                     done_o
);

  localparam int unsigned CntWidth   = varlat_mem_pkg::LatCntWidth;
  localparam int unsigned ExtraWidth = varlat_mem_pkg::LatExtraWidth;

  // worst case must fit the counter
  if (BaseLatency + 2 ** ExtraWidth - 1 >= 2 ** CntWidth) begin : gen_bad_width
    $error("latency counter too narrow for this bank");
  end

  localparam logic [CntWidth-1:0] BaseCnt = CntWidth'(BaseLatency);

  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] load_cnt;

  // total latency of this access
  assign load_cnt = BaseCnt + {{(CntWidth - ExtraWidth){1'b0}}, extra_i};

  // last waiting cycle
  assign done_o = (cnt_q == CntWidth'(1));

  // load on start, then count down to zero and rest there
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= load_cnt;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

endmodule

// ==== design/bank_storage.sv ====
/* Bank storage array */

module bank_storage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // one cycle access strobe
  input  logic                                access_i,
  // packed {we, word, wdata}
  input  logic [varlat_mem_pkg::ReqWidth-1:0] req_data_i,
  output logic [varlat_mem_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned DataWidth = varlat_mem_pkg::DataWidth;
  localparam int unsigned AddrWidth = varlat_mem_pkg::WordAddrWidth;
  localparam int unsigned NumWords  = 2 ** AddrWidth;

  logic                 we;
  logic [AddrWidth-1:0] word;
  logic [DataWidth-1:0] wdata;

  logic [DataWidth-1:0] mem_q [NumWords];
  logic [DataWidth-1:0] rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // request fields
  ////////////////////////////////////////////////////////////////////////////

  assign we    = req_data_i[varlat_mem_pkg::ReqWeBit];
  assign word  = req_data_i[varlat_mem_pkg::ReqWordLsb +: AddrWidth];
  assign wdata = req_data_i[varlat_mem_pkg::ReqWdataLsb +: DataWidth];

  ////////////////////////////////////////////////////////////////////////////
  // array and response
  ////////////////////////////////////////////////////////////////////////////

  // cleared on reset, written at the access edge
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mem
    if (!rst_ni) begin
      for (int i = 0; i < NumWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (access_i && we) begin
      mem_q[word] <= wdata;
    end
  end

  // write returns the new word, read the stored one
  always_ff @(posedge clk_i) begin : p_resp
    if (access_i) begin
      rdata_q <= we ? wdata : mem_q[word];
    end
  end

  // held until the next access
  assign rdata_o = rdata_q;

endmodule

// ==== design/varlat_mem_pkg.sv ====
/* Variable-latency scratchpad
   shared constants */

package varlat_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data and address widths
  ////////////////////////////////////////////////////////////////////////////

  // one data word
  localparam int unsigned DataWidth     = 16;
  // word address inside one bank, 16 words
  localparam int unsigned WordAddrWidth = 4;

  // packed request is {we, word, wdata}
  localparam int unsigned ReqWidth      = 1 + WordAddrWidth + DataWidth;
  localparam int unsigned ReqWdataLsb   = 0;
  localparam int unsigned ReqWordLsb    = ReqWdataLsb + DataWidth;
  localparam int unsigned ReqWeBit      = ReqWordLsb + WordAddrWidth;

  ////////////////////////////////////////////////////////////////////////////
  // latency
  ////////////////////////////////////////////////////////////////////////////

  // low word bits that stretch the access
  localparam int unsigned LatExtraWidth = 2;
  // down counter width, covers base plus extra
  localparam int unsigned LatCntWidth   = 5;

endpackage

// ==== design/varlat_mem_top.sv ====
/* Multi-bank variable-latency scratchpad */

module varlat_mem_top #(
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned MinLatency = 1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // master request
  input  logic                                     req_i,
  input  logic [(NumBanks > 1 ? $clog2(NumBanks) : 1)-1:0] bank_i,
  input  logic                                     we_i,
  input  logic [varlat_mem_pkg::WordAddrWidth-1:0] word_i,
  input  logic [varlat_mem_pkg::DataWidth-1:0]     wdata_i,
  output logic                                     gnt_o,
  // master response
  output logic                                     vld_o,
  output logic [varlat_mem_pkg::DataWidth-1:0]     rdata_o
);

  localparam int unsigned ReqWidth  = varlat_mem_pkg::ReqWidth;
  localparam int unsigned DataWidth = varlat_mem_pkg::DataWidth;

  logic [ReqWidth-1:0]                req_data;
  logic [NumBanks-1:0]                bank_req;
  logic [NumBanks-1:0]                bank_gnt;
  logic [NumBanks-1:0]                bank_vld;
  logic [NumBanks-1:0][ReqWidth-1:0]  bank_data;
  logic [NumBanks-1:0][DataWidth-1:0] bank_rdata;

  // pack {we, word, wdata}
  assign req_data[varlat_mem_pkg::ReqWeBit] = we_i;
  assign req_data[varlat_mem_pkg::ReqWordLsb +: varlat_mem_pkg::WordAddrWidth] = word_i;
  assign req_data[varlat_mem_pkg::ReqWdataLsb +: DataWidth] = wdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // decoder and response mux
  ////////////////////////////////////////////////////////////////////////////

  addr_dec_resp_mux_varlat #(
    .NumOut       (NumBanks),
    .ReqDataWidth (ReqWidth),
    .RespDataWidth(DataWidth)
  ) i_addr_dec_resp_mux (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .add_i  (bank_i),
    .data_i (req_data),
    .gnt_o  (gnt_o),
    .vld_o  (vld_o),
    .rdata_o(rdata_o),
    .req_o  (bank_req),
    .data_o (bank_data),
    .gnt_i  (bank_gnt),
    .vld_i  (bank_vld),
    .rdata_i(bank_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // bank slices
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic access;
    logic timer_start;
    logic timer_done;

    // later banks are slower by one cycle each
    bank_ctrl_fsm #(
      .BaseLatency(MinLatency + b)
    ) i_bank_ctrl_fsm (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .timer_done_i (timer_done),
      .gnt_o        (bank_gnt[b]),
      .access_o     (access),
      .timer_start_o(timer_start),
      .vld_o        (bank_vld[b])
    );

    // extra delay from the low word bits
    bank_latency_timer #(
      .BaseLatency(MinLatency + b)
    ) i_bank_latency_timer (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .start_i(timer_start),
      .extra_i(bank_data[b][varlat_mem_pkg::ReqWordLsb +: varlat_mem_pkg::LatExtraWidth]),
      .done_o (timer_done)
    );

    bank_storage i_bank_storage (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .access_i  (access),
      .req_data_i(bank_data[b]),
      .rdata_o   (bank_rdata[b])
    );
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the scratchpad testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module varlat_mem_tb \
  -f varlat_mem.f \
  --Mdir obj_dir \
  -o varlat_mem_sim

# nonzero exit status on any failure
./obj_dir/varlat_mem_sim

// ==== tests/varlat_mem_checker.sv ====
/* Scratchpad handshake assertions */

module varlat_mem_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  // top level gnt_o and vld_o
  input logic gnt_i,
  input logic vld_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // accepted, response not yet seen
  logic pending_q;

  // a new acceptance in the response cycle keeps it set
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (req_i && gnt_i) begin
      pending_q <= 1'b1;
    end else if (vld_i) begin
      pending_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  // single cycle response strobe
  a_vld_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    vld_i |=> !vld_i)
    else $error("vld_o high on two consecutive cycles");

  // no grant without a request
  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_i)
    else $error("gnt_o high while req_i is low");

  // in flight, only the response cycle reopens the port
  a_one_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pending_q && !vld_i) |-> !gnt_i)
    else $error("second grant before the response");

  // every response belongs to an accepted request
  a_vld_pending : assert property (@(posedge clk_i) disable iff (!rst_ni)
    vld_i |-> pending_q)
    else $error("vld_o without an outstanding request");

endmodule

bind varlat_mem_top varlat_mem_checker i_varlat_mem_checker (
  .clk_i (clk_i),
  .rst_ni(rst_ni),
  .req_i (req_i),
  .gnt_i (gnt_o),
  .vld_i (vld_o)
);

// ==== tests/varlat_mem_tb.sv ====
/* Scratchpad testbench */

module varlat_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumBanks       = 4;
  localparam int unsigned MinLatency     = 1;
  localparam int unsigned BankWidth      = 2;
  localparam int unsigned DataWidth      = varlat_mem_pkg::DataWidth;
  localparam int unsigned WordWidth      = varlat_mem_pkg::WordAddrWidth;
  localparam int unsigned NumWords       = 2 ** WordWidth;
  localparam int unsigned NumEntries     = 16;
  localparam int unsigned NumRandom      = 48;
  localparam int unsigned ClkPeriod      = 100;
  // 40 cycles per transaction plus reset
  localparam int unsigned WatchdogCycles = 40 * (NumEntries + NumRandom) + 10;

  typedef struct packed {
    logic [BankWidth-1:0] bank;
    logic                 we;
    logic [WordWidth-1:0] word;
    logic [DataWidth-1:0] wdata;
    // cycles from acceptance to vld_o
    logic [3:0]           lat;
    // idle cycles before the request
    // zero keeps req_i high
    logic [1:0]           gap;
  } entry_t;

  ////////////////////////////////////////////////////////////////////////////
  // directed table
  ////////////////////////////////////////////////////////////////////////////

  localparam entry_t Table [NumEntries] = '{
    // untouched words read as zero
    '{2'd0, 1'b0, 4'd0,  16'h0000, 4'd1, 2'd1},
    '{2'd1, 1'b0, 4'd5,  16'h0000, 4'd3, 2'd0},
    '{2'd2, 1'b0, 4'd10, 16'h0000, 4'd5, 2'd0},
    '{2'd3, 1'b0, 4'd15, 16'h0000, 4'd7, 2'd0},
    // same word in all banks starting with bank 1
    '{2'd1, 1'b1, 4'd6,  16'h1234, 4'd4, 2'd1},
    '{2'd0, 1'b1, 4'd6,  16'haaaa, 4'd3, 2'd0},
    '{2'd2, 1'b1, 4'd6,  16'h5555, 4'd5, 2'd0},
    '{2'd3, 1'b1, 4'd6,  16'h0f0f, 4'd6, 2'd0},
    // read back with two in a row to one bank
    '{2'd1, 1'b0, 4'd6,  16'h0000, 4'd4, 2'd0},
    '{2'd1, 1'b0, 4'd6,  16'h0000, 4'd4, 2'd0},
    '{2'd0, 1'b0, 4'd6,  16'h0000, 4'd3, 2'd2},
    '{2'd3, 1'b0, 4'd6,  16'h0000, 4'd6, 2'd0},
    // slowest bank and word
    '{2'd3, 1'b1, 4'd3,  16'hbeef, 4'd7, 2'd0},
    '{2'd3, 1'b0, 4'd3,  16'h0000, 4'd7, 2'd0},
    '{2'd2, 1'b0, 4'd4,  16'h0000, 4'd3, 2'd3},
    '{2'd0, 1'b1, 4'd1,  16'hc0de, 4'd2, 2'd0}
  };

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  logic [BankWidth-1:0] bank_i;
  logic                 we_i;
  logic [WordWidth-1:0] word_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 gnt_o;
  logic                 vld_o;
  logic [DataWidth-1:0] rdata_o;

  // expected memory contents
  logic [DataWidth-1:0] model_mem [NumBanks][NumWords];

  // one entry per accepted request
  // popped by its response
  logic [DataWidth-1:0] exp_data_q [$];
  int unsigned          exp_lat_q [$];
  int unsigned          acc_cycle_q [$];

  int unsigned cycle_cnt;
  int unsigned resp_cnt;
  logic [31:0] lfsr_q;

  varlat_mem_top #(
    .NumBanks  (NumBanks),
    .MinLatency(MinLatency)
  ) i_varlat_mem_top (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (req_i),
    .bank_i (bank_i),
    .we_i   (we_i),
    .word_i (word_i),
    .wdata_i(wdata_i),
    .gnt_o  (gnt_o),
    .vld_o  (vld_o),
    .rdata_o(rdata_o)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2);
      clk_i = ~clk_i;
    end
  end

  // edge count for latency
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cycle_cnt
    if (!rst_ni) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // called and returns at a rising edge
  task automatic issue(input entry_t e);
    if (e.gap != 0) begin
      req_i <= 1'b0;
      repeat (e.gap) @(posedge clk_i);
    end
    req_i   <= 1'b1;
    bank_i  <= e.bank;
    we_i    <= e.we;
    word_i  <= e.word;
    wdata_i <= e.wdata;
    // hold until granted
    do begin
      @(negedge clk_i);
    end while (!gnt_o);
    // access lands on the coming edge
    if (e.we) begin
      model_mem[e.bank][e.word] = e.wdata;
    end
    exp_data_q.push_back(model_mem[e.bank][e.word]);
    exp_lat_q.push_back(32'(e.lat));
    acc_cycle_q.push_back(cycle_cnt + 1);
    @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_monitor
    int unsigned          acc;
    int unsigned          elat;
    logic [DataWidth-1:0] edata;
    resp_cnt = 0;
    forever begin
      @(negedge clk_i);
      if (vld_o) begin
        if (exp_data_q.size() == 0) begin
          $display("vld_o high at %0t ns with no request outstanding", $time);
          $display("Done: errors found");
          $fatal(1, "response without a request");
        end else begin
          acc   = acc_cycle_q.pop_front();
          elat  = exp_lat_q.pop_front();
          edata = exp_data_q.pop_front();
          check_value(32'(rdata_o), 32'(edata), $sformatf("rdata of response %0d", resp_cnt));
          check_value(cycle_cnt - acc, elat, $sformatf("latency of response %0d", resp_cnt));
          resp_cnt++;
        end
      end
    end
  end

  initial begin : p_watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a transaction never completed",
             WatchdogCycles);
    $display("Done: errors found");
    $fatal(1, "watchdog timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    entry_t e;
    rst_ni     = 1'b0;
    req_i      = 1'b0;
    bank_i     = '0;
    we_i       = 1'b0;
    word_i     = '0;
    wdata_i    = '0;
    lfsr_q     = 32'ha385;
    for (int b = 0; b < NumBanks; b++) begin
      for (int w = 0; w < NumWords; w++) begin
        model_mem[b][w] = '0;
      end
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value(32'(gnt_o), 32'd0, "gnt_o after reset");
    check_value(32'(vld_o), 32'd0, "vld_o after reset");
    @(posedge clk_i);

    for (int i = 0; i < NumEntries; i++) begin
      issue(Table[i]);
    end

    // random fields and gaps
    for (int i = 0; i < NumRandom; i++) begin
      e.bank  = 2'(rand_bits(BankWidth));
      e.we    = 1'(rand_bits(1));
      e.word  = 4'(rand_bits(WordWidth));
      e.wdata = 16'(rand_bits(DataWidth));
      e.gap   = 2'(rand_bits(2));
      e.lat   = 4'(MinLatency + e.bank + e.word[1:0]);
      issue(e);
    end

    req_i <= 1'b0;
    while (exp_data_q.size() != 0) begin
      @(posedge clk_i);
    end
    // quiet bus to catch stray responses
    repeat (10) @(posedge clk_i);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== varlat_mem.f ====
design/varlat_mem_pkg.sv
design/addr_dec_resp_mux_varlat.sv
design/bank_ctrl_fsm.sv
design/bank_latency_timer.sv
design/bank_storage.sv
design/varlat_mem_top.sv
tests/varlat_mem_checker.sv
tests/varlat_mem_tb.sv
